//--- verilog/pkt_parse_pkg.sv
// Shared widths, header layout and the ECC and CRC-8 functions; CRC-8 starts at zero, runs MSB first and is not reflected
package pkt_parse_pkg;

	////////////////////////////////////////////////////////////
	// Widths and types
	////////////////////////////////////////////////////////////

	localparam int WORD_W = 32;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [7:0]        byte_t;
	typedef logic [3:0]        nibble_t;
	typedef logic [2:0]        sop_t;

	////////////////////////////////////////////////////////////
	// Header word layout
	////////////////////////////////////////////////////////////

	// Hamming check bits
	localparam int HDR_ECC_LSB  = 0;
	// Payload byte count, number of bytes minus one
	localparam int HDR_CNT_LSB  = 4;
	localparam int HDR_TYPE_LSB = 8;
	// Even parity over type and count
	localparam int HDR_PAR_BIT  = 12;
	localparam int HDR_SOP_LSB  = 13;

	// Words from header to first payload byte
	localparam int HDR_SKIP = 2;

	localparam byte_t CRC_POLY = 8'h07;

	////////////////////////////////////////////////////////////
	// Functions
	////////////////////////////////////////////////////////////

	// Check bits for data {type, count}
	function automatic nibble_t ecc_encode(input byte_t d);
		nibble_t c;
		c[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6];
		c[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6];
		c[2] = d[1] ^ d[2] ^ d[3] ^ d[7];
		c[3] = d[4] ^ d[5] ^ d[6] ^ d[7];
		return c;
	endfunction

	// One byte folded into the running CRC
	function automatic byte_t crc8_update(input byte_t crc, input byte_t data);
		byte_t c;
		c = crc ^ data;
		// MSB first, one shift per data bit
		for (int i = 0; i < 8; i++) begin
			if (c[7]) begin
				c = {c[6:0], 1'b0} ^ CRC_POLY;
			end else begin
				c = {c[6:0], 1'b0};
			end
		end
		return c;
	endfunction

endpackage

//--- verilog/pkt_mem.sv
// Packet memory of 2^ADDR_W words without reset; a read returns the word one cycle later and sees old data on a same-cycle write
module pkt_mem #(
	parameter int ADDR_W = 14
) (
	input  logic                  clk,
	// Load port
	input  logic                  we_i,
	input  logic [ADDR_W-1:0]     waddr_i,
	input  pkt_parse_pkg::word_t  wdata_i,
	// Header read port
	input  logic [ADDR_W-1:0]     hdr_raddr_i,
	output pkt_parse_pkg::word_t  hdr_rdata_o,
	// Payload read port
	input  logic [ADDR_W-1:0]     pay_raddr_i,
	output pkt_parse_pkg::word_t  pay_rdata_o
);

	pkt_parse_pkg::word_t mem [2**ADDR_W];

	// Write from the outside agent
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	// Two registered read ports
	always_ff @(posedge clk) begin
		hdr_rdata_o <= mem[hdr_raddr_i];
		pay_rdata_o <= mem[pay_raddr_i];
	end

endmodule

//--- verilog/hdr_ecc_check.sv
// Header ECC check; done follows go by exactly 3 cycles and the fields hold until the next check
module hdr_ecc_check #(
	parameter int ADDR_W = 14
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     go_i,
	input  logic [ADDR_W-1:0]        addr_hdr_i,
	output logic [ADDR_W-1:0]        hdr_raddr_o,
	input  pkt_parse_pkg::word_t     hdr_rdata_i,
	output logic                     hdr_done_o,
	output pkt_parse_pkg::nibble_t   byte_cnt_o,
	output pkt_parse_pkg::nibble_t   pkt_type_o,
	output logic                     ecc_corr_o,
	output logic                     ecc_uncorr_o
);

	logic [ADDR_W-1:0]       addr_q;
	// Pipeline of go through read, check and done
	logic                    rd_q;
	logic                    chk_q;
	logic                    done_q;
	pkt_parse_pkg::byte_t    data_raw;
	pkt_parse_pkg::byte_t    data_fix;
	pkt_parse_pkg::byte_t    data_q;
	pkt_parse_pkg::byte_t    flip;
	pkt_parse_pkg::nibble_t  syndrome;
	logic                    par_diff;
	logic                    single_data;
	logic                    single_chk;
	logic                    corr;
	logic                    uncorr;

	assign hdr_raddr_o = addr_q;

	////////////////////////////////////////////////////////////
	// Syndrome and error class
	////////////////////////////////////////////////////////////

	always_comb begin
		// Type in high nibble, count in low nibble
		data_raw = {hdr_rdata_i[pkt_parse_pkg::HDR_TYPE_LSB +: 4],
			hdr_rdata_i[pkt_parse_pkg::HDR_CNT_LSB +: 4]};
		syndrome = hdr_rdata_i[pkt_parse_pkg::HDR_ECC_LSB +: 4]
			^ pkt_parse_pkg::ecc_encode(data_raw);
		par_diff = (^data_raw) ^ hdr_rdata_i[pkt_parse_pkg::HDR_PAR_BIT];
		// Match syndrome against each data bit column
		flip = '0;
		for (int i = 0; i < 8; i++) begin
			if (syndrome == pkt_parse_pkg::ecc_encode(8'b1 << i)) begin
				flip[i] = 1'b1;
			end
		end
		single_data = (|flip) && par_diff;
		// Check-bit error leaves data parity intact
		single_chk  = $onehot(syndrome) && !par_diff;
		corr        = single_data || single_chk;
		uncorr      = (syndrome != '0) && !corr;
		data_fix    = single_data ? (data_raw ^ flip) : data_raw;
	end

	////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (go_i) begin
			addr_q <= addr_hdr_i;
		end
		// Results sampled in the cycle the header word is on the bus
		if (chk_q) begin
			data_q <= data_fix;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_q         <= 1'b0;
			chk_q        <= 1'b0;
			done_q       <= 1'b0;
			ecc_corr_o   <= 1'b0;
			ecc_uncorr_o <= 1'b0;
		end else begin
			rd_q   <= go_i;
			chk_q  <= rd_q;
			done_q <= chk_q;
			if (chk_q) begin
				ecc_corr_o   <= corr;
				ecc_uncorr_o <= uncorr;
			end
		end
	end

	assign hdr_done_o = done_q;
	assign byte_cnt_o = data_q[3:0];
	assign pkt_type_o = data_q[7:4];

endmodule

//--- verilog/payload_crc.sv
// Payload CRC-8 walk of byte_cnt+1 bytes plus the CRC word; addr_hdr_i must hold while the walk runs
module payload_crc #(
	parameter int ADDR_W = 14
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     hdr_done_i,
	input  logic                     ecc_uncorr_i,
	input  logic                     ignore_ecc_err_i,
	input  logic [ADDR_W-1:0]        addr_hdr_i,
	input  pkt_parse_pkg::nibble_t   byte_cnt_i,
	output logic [ADDR_W-1:0]        pay_raddr_o,
	input  pkt_parse_pkg::word_t     pay_rdata_i,
	output logic                     crc_done_o,
	output logic                     crc_err_o
);

	typedef enum logic [1:0] {
		IDLE,
		READ,
		COMPARE
	} state_t;

	state_t                  state_q;
	logic                    launch;
	logic [ADDR_W-1:0]       addr_q;
	pkt_parse_pkg::nibble_t  cnt_q;
	// Index of the next read; the CRC word has index cnt+1
	logic [4:0]              rd_idx_q;
	logic [4:0]              last_idx;
	logic                    issue;
	// Returned-data tags, one cycle behind the read
	logic                    vld_q;
	logic                    last_q;
	pkt_parse_pkg::byte_t    crc_q;
	pkt_parse_pkg::byte_t    stored_q;

	// Uncorrectable header stops the walk unless overridden
	assign launch   = hdr_done_i && !(ecc_uncorr_i && !ignore_ecc_err_i);
	assign last_idx = {1'b0, cnt_q} + 5'd1;
	assign issue    = (state_q == READ) && (rd_idx_q <= last_idx);

	assign pay_raddr_o = addr_q;

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q  <= IDLE;
			rd_idx_q <= '0;
			vld_q    <= 1'b0;
			last_q   <= 1'b0;
		end else begin
			vld_q  <= issue;
			last_q <= issue && (rd_idx_q == last_idx);
			case (state_q)
				IDLE: begin
					if (launch) begin
						rd_idx_q <= '0;
						state_q  <= READ;
					end
				end
				READ: begin
					if (issue) begin
						rd_idx_q <= rd_idx_q + 5'd1;
					end
					// Stored CRC byte arrives last
					if (vld_q && last_q) begin
						state_q <= COMPARE;
					end
				end
				COMPARE: state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Address and CRC datapath
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if ((state_q == IDLE) && launch) begin
			addr_q <= addr_hdr_i + ADDR_W'(pkt_parse_pkg::HDR_SKIP);
			cnt_q  <= byte_cnt_i;
			crc_q  <= '0;
		end else begin
			if (issue) begin
				addr_q <= addr_q + 1'b1;
			end
			if (vld_q && !last_q) begin
				crc_q <= pkt_parse_pkg::crc8_update(crc_q, pay_rdata_i[7:0]);
			end
			if (vld_q && last_q) begin
				stored_q <= pay_rdata_i[7:0];
			end
		end
	end

	assign crc_done_o = (state_q == COMPARE);
	assign crc_err_o  = (state_q == COMPARE) && (crc_q != stored_q);

endmodule

//--- verilog/parse_status.sv
// Parse status; start is dropped while busy and results hold from irq until the next accepted start
module parse_status (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     start_i,
	output logic                     go_o,
	input  logic                     hdr_done_i,
	input  pkt_parse_pkg::nibble_t   byte_cnt_i,
	input  pkt_parse_pkg::nibble_t   pkt_type_i,
	input  logic                     ecc_corr_i,
	input  logic                     ecc_uncorr_i,
	input  logic                     ignore_ecc_err_i,
	input  logic                     crc_done_i,
	input  logic                     crc_err_i,
	output logic                     busy_o,
	output logic                     irq_o,
	output logic                     ecc_corr_o,
	output logic                     ecc_uncorr_o,
	output logic                     crc_err_o,
	output pkt_parse_pkg::nibble_t   pkt_byte_cnt_o,
	output pkt_parse_pkg::nibble_t   pkt_type_o
);

	logic accept;
	logic abort;
	logic finish;

	assign accept = start_i && !busy_o;
	assign go_o   = accept;
	// No CRC walk follows an uncorrectable header
	assign abort  = hdr_done_i && ecc_uncorr_i && !ignore_ecc_err_i;
	assign finish = abort || crc_done_i;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_o         <= 1'b0;
			irq_o          <= 1'b0;
			ecc_corr_o     <= 1'b0;
			ecc_uncorr_o   <= 1'b0;
			crc_err_o      <= 1'b0;
			pkt_byte_cnt_o <= '0;
			pkt_type_o     <= '0;
		end else begin
			irq_o <= busy_o && finish;
			// Busy drops in the irq cycle
			if (accept) begin
				busy_o <= 1'b1;
			end else if (finish) begin
				busy_o <= 1'b0;
			end
			if (accept) begin
				ecc_corr_o   <= 1'b0;
				ecc_uncorr_o <= 1'b0;
				crc_err_o    <= 1'b0;
			end else begin
				if (hdr_done_i) begin
					ecc_corr_o     <= ecc_corr_i;
					ecc_uncorr_o   <= ecc_uncorr_i;
					pkt_byte_cnt_o <= byte_cnt_i;
					pkt_type_o     <= pkt_type_i;
				end
				if (crc_done_i) begin
					crc_err_o <= crc_err_i;
				end
			end
		end
	end

endmodule

//--- verilog/pkt_parse_top.sv
// Packet parser top; load only while idle and hold addr_hdr_i and ignore_ecc_err_i stable while busy_o is high
module pkt_parse_top #(
	parameter int ADDR_W = 14
) (
	input  logic                     clk,
	input  logic                     reset,
	// Memory load
	input  logic                     load_we_i,
	input  logic [ADDR_W-1:0]        load_addr_i,
	input  pkt_parse_pkg::word_t     load_data_i,
	// Parse control
	input  logic                     start_i,
	input  logic [ADDR_W-1:0]        addr_hdr_i,
	input  logic                     ignore_ecc_err_i,
	// Status and results
	output logic                     busy_o,
	output logic                     irq_o,
	output logic                     ecc_corr_o,
	output logic                     ecc_uncorr_o,
	output logic                     crc_err_o,
	output pkt_parse_pkg::nibble_t   pkt_byte_cnt_o,
	output pkt_parse_pkg::nibble_t   pkt_type_o
);

	logic [ADDR_W-1:0]       hdr_raddr;
	pkt_parse_pkg::word_t    hdr_rdata;
	logic [ADDR_W-1:0]       pay_raddr;
	pkt_parse_pkg::word_t    pay_rdata;
	logic                    go;
	logic                    hdr_done;
	pkt_parse_pkg::nibble_t  byte_cnt;
	pkt_parse_pkg::nibble_t  pkt_type;
	logic                    ecc_corr;
	logic                    ecc_uncorr;
	logic                    crc_done;
	logic                    crc_err;

	pkt_mem #(.ADDR_W(ADDR_W)) u_mem (
		.clk(clk), .we_i(load_we_i), .waddr_i(load_addr_i), .wdata_i(load_data_i),
		.hdr_raddr_i(hdr_raddr), .hdr_rdata_o(hdr_rdata),
		.pay_raddr_i(pay_raddr), .pay_rdata_o(pay_rdata)
	);

	hdr_ecc_check #(.ADDR_W(ADDR_W)) u_ecc (
		.clk(clk), .reset(reset), .go_i(go), .addr_hdr_i(addr_hdr_i),
		.hdr_raddr_o(hdr_raddr), .hdr_rdata_i(hdr_rdata), .hdr_done_o(hdr_done),
		.byte_cnt_o(byte_cnt), .pkt_type_o(pkt_type),
		.ecc_corr_o(ecc_corr), .ecc_uncorr_o(ecc_uncorr)
	);

	payload_crc #(.ADDR_W(ADDR_W)) u_crc (
		.clk(clk), .reset(reset), .hdr_done_i(hdr_done), .ecc_uncorr_i(ecc_uncorr),
		.ignore_ecc_err_i(ignore_ecc_err_i), .addr_hdr_i(addr_hdr_i), .byte_cnt_i(byte_cnt),
		.pay_raddr_o(pay_raddr), .pay_rdata_i(pay_rdata),
		.crc_done_o(crc_done), .crc_err_o(crc_err)
	);

	parse_status u_status (
		.clk(clk), .reset(reset), .start_i(start_i), .go_o(go),
		.hdr_done_i(hdr_done), .byte_cnt_i(byte_cnt), .pkt_type_i(pkt_type),
		.ecc_corr_i(ecc_corr), .ecc_uncorr_i(ecc_uncorr),
		.ignore_ecc_err_i(ignore_ecc_err_i), .crc_done_i(crc_done), .crc_err_i(crc_err),
		.busy_o(busy_o), .irq_o(irq_o), .ecc_corr_o(ecc_corr_o),
		.ecc_uncorr_o(ecc_uncorr_o), .crc_err_o(crc_err_o),
		.pkt_byte_cnt_o(pkt_byte_cnt_o), .pkt_type_o(pkt_type_o)
	);

endmodule

//--- test/pkt_parse_checker.sv
// Output protocol assertions bound into pkt_parse_top; checks hold only while reset is low except the reset check
module pkt_parse_checker (
	input logic clk,
	input logic reset,
	input logic busy_i,
	input logic irq_i,
	input logic ecc_corr_i,
	input logic ecc_uncorr_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// Interrupt is a single-cycle pulse
	a_irq_single: assert property (@(posedge clk) disable iff (reset) irq_i |=> !irq_i)
		else $error("irq_o stayed high for more than one cycle");

	// Interrupt only ends a parse that was running
	a_irq_busy: assert property (@(posedge clk) disable iff (reset) irq_i |-> $past(busy_i))
		else $error("irq_o without busy_o in the previous cycle");

	// Corrected and uncorrectable are exclusive
	a_ecc_excl: assert property (@(posedge clk) disable iff (reset)
		!(ecc_corr_i && ecc_uncorr_i))
		else $error("ecc_corr_o and ecc_uncorr_o both high");

	// Parser idle right after reset
	a_reset_idle: assert property (@(posedge clk) reset |=> !busy_i)
		else $error("busy_o high in the cycle after reset");

endmodule

bind pkt_parse_top pkt_parse_checker u_checker (
	.clk(clk), .reset(reset), .busy_i(busy_o), .irq_i(irq_o),
	.ecc_corr_i(ecc_corr_o), .ecc_uncorr_i(ecc_uncorr_o)
);

//--- test/tb_pkt_parse.sv
// Directed parser tests; inputs change 10 ns after the rising edge and outputs are read there too
module tb_pkt_parse;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ADDR_W      = 14;
	// Longest parse is about 22 cycles for a 16-byte payload
	localparam int PARSE_LIMIT = 32;
	// Header, gap word, 16 payload words and the CRC word
	localparam int MAX_WORDS   = 19;
	localparam int N_PARSES    = 20;
	localparam int N_LOADS     = 20;
	localparam int MAX_CYCLES  = N_PARSES * (PARSE_LIMIT + 1) + N_LOADS * (MAX_WORDS + 1) + 100;
	localparam pkt_parse_pkg::sop_t SOP = 3'b101;

	logic                    clk;
	logic                    reset;
	logic                    load_we_i;
	logic [ADDR_W-1:0]       load_addr_i;
	pkt_parse_pkg::word_t    load_data_i;
	logic                    start_i;
	logic [ADDR_W-1:0]       addr_hdr_i;
	logic                    ignore_ecc_err_i;
	logic                    busy_o;
	logic                    irq_o;
	logic                    ecc_corr_o;
	logic                    ecc_uncorr_o;
	logic                    crc_err_o;
	pkt_parse_pkg::nibble_t  pkt_byte_cnt_o;
	pkt_parse_pkg::nibble_t  pkt_type_o;

	// Copy of every word written into the packet memory
	pkt_parse_pkg::word_t    shadow [2**ADDR_W];
	logic [31:0]             rng_state = 32'd30091;
	int                      errors = 0;
	int                      errors_at_start = 0;
	int                      tests_passed = 0;
	int                      tests_failed = 0;
	int                      cycles = 0;

	pkt_parse_top #(.ADDR_W(ADDR_W)) dut (
		.clk(clk), .reset(reset),
		.load_we_i(load_we_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i),
		.start_i(start_i), .addr_hdr_i(addr_hdr_i), .ignore_ecc_err_i(ignore_ecc_err_i),
		.busy_o(busy_o), .irq_o(irq_o), .ecc_corr_o(ecc_corr_o),
		.ecc_uncorr_o(ecc_uncorr_o), .crc_err_o(crc_err_o),
		.pkt_byte_cnt_o(pkt_byte_cnt_o), .pkt_type_o(pkt_type_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Watchdog
	initial begin
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Hamming check bits over {type, count}
	function automatic pkt_parse_pkg::nibble_t model_check_bits(input pkt_parse_pkg::byte_t d);
		pkt_parse_pkg::nibble_t c;
		c[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6];
		c[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6];
		c[2] = d[1] ^ d[2] ^ d[3] ^ d[7];
		c[3] = d[4] ^ d[5] ^ d[6] ^ d[7];
		return c;
	endfunction

	// Bit-serial CRC-8 with poly 0x07 taken MSB first
	function automatic pkt_parse_pkg::byte_t model_crc8(input pkt_parse_pkg::byte_t crc,
		input pkt_parse_pkg::byte_t data);
		pkt_parse_pkg::byte_t c;
		logic fb;
		c = crc;
		for (int i = 7; i >= 0; i--) begin
			fb = c[7] ^ data[i];
			c  = {c[6:0], 1'b0};
			if (fb) begin
				c = c ^ 8'h07;
			end
		end
		return c;
	endfunction

	// CRC mismatch for a walk of cnt+1 bytes from the memory copy
	function automatic logic model_crc_err(input logic [ADDR_W-1:0] base,
		input pkt_parse_pkg::nibble_t cnt);
		pkt_parse_pkg::byte_t crc;
		logic [ADDR_W-1:0] a;
		crc = '0;
		a   = base + ADDR_W'(pkt_parse_pkg::HDR_SKIP);
		for (int k = 0; k <= int'(cnt); k++) begin
			crc = model_crc8(crc, shadow[a][7:0]);
			a   = a + ADDR_W'(1);
		end
		return crc != shadow[a][7:0];
	endfunction

	////////////////////////////////////////////////////////////
	// Drive and compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR at %0d ns: %s expected %0b actual %0b", $time, name, expected, actual);
			errors = errors + 1;
		end
	endtask

	task automatic check_nibble(input string name, input pkt_parse_pkg::nibble_t expected,
		input pkt_parse_pkg::nibble_t actual);
		if (actual !== expected) begin
			$display("ERROR at %0d ns: %s expected %h actual %h", $time, name, expected, actual);
			errors = errors + 1;
		end
	endtask

	task automatic check_results(input logic corr, input logic uncorr, input logic crc_err,
		input pkt_parse_pkg::nibble_t cnt, input pkt_parse_pkg::nibble_t typ);
		check_flag("ecc_corr_o", corr, ecc_corr_o);
		check_flag("ecc_uncorr_o", uncorr, ecc_uncorr_o);
		check_flag("crc_err_o", crc_err, crc_err_o);
		check_nibble("pkt_byte_cnt_o", cnt, pkt_byte_cnt_o);
		check_nibble("pkt_type_o", typ, pkt_type_o);
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] addr, input pkt_parse_pkg::word_t data);
		load_we_i   = 1'b1;
		load_addr_i = addr;
		load_data_i = data;
		shadow[addr] = data;
		@(posedge clk);
		#10;
		load_we_i = 1'b0;
	endtask

	// Header, gap, payload and CRC word; flips hit header bits [12:0]
	task automatic load_packet(input logic [ADDR_W-1:0] base, input pkt_parse_pkg::nibble_t cnt,
		input pkt_parse_pkg::nibble_t typ, input logic [12:0] flips,
		input pkt_parse_pkg::byte_t crc_xor);
		pkt_parse_pkg::word_t hdr;
		pkt_parse_pkg::word_t w;
		pkt_parse_pkg::byte_t crc;
		logic [ADDR_W-1:0] a;
		hdr = '0;
		hdr[pkt_parse_pkg::HDR_ECC_LSB +: 4]  = model_check_bits({typ, cnt});
		hdr[pkt_parse_pkg::HDR_CNT_LSB +: 4]  = cnt;
		hdr[pkt_parse_pkg::HDR_TYPE_LSB +: 4] = typ;
		hdr[pkt_parse_pkg::HDR_PAR_BIT]       = ^{typ, cnt};
		hdr[pkt_parse_pkg::HDR_SOP_LSB +: 3]  = SOP;
		hdr[12:0] = hdr[12:0] ^ flips;
		write_word(base, hdr);
		for (int g = 1; g < pkt_parse_pkg::HDR_SKIP; g++) begin
			write_word(base + ADDR_W'(g), rand_word());
		end
		crc = '0;
		a   = base + ADDR_W'(pkt_parse_pkg::HDR_SKIP);
		for (int k = 0; k <= int'(cnt); k++) begin
			w   = rand_word();
			crc = model_crc8(crc, w[7:0]);
			write_word(a, w);
			a = a + ADDR_W'(1);
		end
		w = rand_word();
		w[7:0] = crc ^ crc_xor;
		write_word(a, w);
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		while (!irq_o && n < PARSE_LIMIT) begin
			@(posedge clk);
			#10;
			n = n + 1;
		end
		if (!irq_o) begin
			$display("No irq_o within %0d cycles after start", PARSE_LIMIT);
			errors = errors + 1;
		end else begin
			// Busy falls together with the interrupt
			check_flag("busy_o", 1'b0, busy_o);
		end
	endtask

	task automatic run_parse(input logic [ADDR_W-1:0] base);
		addr_hdr_i = base;
		start_i    = 1'b1;
		@(posedge clk);
		#10;
		start_i = 1'b0;
		check_flag("busy_o", 1'b1, busy_o);
		wait_irq();
	endtask

	task automatic begin_test();
		errors_at_start = errors;
	endtask

	task automatic end_test(input string name);
		if (errors == errors_at_start) begin
			tests_passed = tests_passed + 1;
			$display("PASS  %s", name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("FAIL  %s (%0d errors)", name, errors - errors_at_start);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic test_clean_packet();
		begin_test();
		load_packet(14'h0040, 4'd9, 4'h3, '0, '0);
		run_parse(14'h0040);
		check_results(1'b0, 1'b0, 1'b0, 4'd9, 4'h3);
		end_test("clean packet");
	endtask

	task automatic test_bad_crc();
		begin_test();
		load_packet(14'h0080, 4'd5, 4'hA, '0, 8'h5A);
		run_parse(14'h0080);
		check_results(1'b0, 1'b0, 1'b1, 4'd5, 4'hA);
		end_test("corrupted CRC byte");
	endtask

	task automatic test_single_flip();
		begin_test();
		// Count bit 1 and then check bit 2
		load_packet(14'h00C0, 4'd6, 4'hC, 13'h0020, '0);
		run_parse(14'h00C0);
		check_results(1'b1, 1'b0, 1'b0, 4'd6, 4'hC);
		load_packet(14'h00C0, 4'd6, 4'hC, 13'h0004, '0);
		run_parse(14'h00C0);
		check_results(1'b1, 1'b0, 1'b0, 4'd6, 4'hC);
		end_test("single bit flips");
	endtask

	task automatic test_double_flip();
		logic exp_crc;
		begin_test();
		// Count 7 read back as 4 after flipping bits 0 and 1
		load_packet(14'h0140, 4'd7, 4'h5, 13'h0030, '0);
		ignore_ecc_err_i = 1'b0;
		run_parse(14'h0140);
		check_results(1'b0, 1'b1, 1'b0, 4'd4, 4'h5);
		ignore_ecc_err_i = 1'b1;
		exp_crc = model_crc_err(14'h0140, 4'd4);
		run_parse(14'h0140);
		check_results(1'b0, 1'b1, exp_crc, 4'd4, 4'h5);
		ignore_ecc_err_i = 1'b0;
		end_test("double bit flip");
	endtask

	task automatic test_restart_and_random();
		logic [31:0] r;
		logic [ADDR_W-1:0] base;
		pkt_parse_pkg::nibble_t cnt;
		pkt_parse_pkg::nibble_t typ;
		logic [12:0] flips;
		int sel;
		int irqs;
		logic exp_corr;
		begin_test();
		load_packet(14'h0100, 4'd2, 4'h7, '0, '0);
		addr_hdr_i = 14'h0100;
		start_i    = 1'b1;
		@(posedge clk);
		#10;
		// Start stays high through every busy cycle up to the last one
		check_flag("busy_o", 1'b1, busy_o);
		irqs = 0;
		wait_irq();
		// Low again before the edge that ends the irq cycle
		start_i = 1'b0;
		if (irq_o) begin
			irqs = irqs + 1;
		end
		repeat (PARSE_LIMIT) begin
			@(posedge clk);
			#10;
			if (irq_o) begin
				irqs = irqs + 1;
			end
		end
		if (irqs != 1) begin
			$display("Start while busy: expected one irq_o pulse but saw %0d", irqs);
			errors = errors + 1;
		end
		check_results(1'b0, 1'b0, 1'b0, 4'd2, 4'h7);
		// Random packets with a flip in bits 0..12 or none
		for (int i = 0; i < 10; i++) begin
			r     = rand_word();
			cnt   = r[3:0];
			typ   = r[7:4];
			sel   = int'(r[11:8]);
			flips = (sel < 13) ? (13'd1 << sel) : 13'd0;
			// Parity bit flip leaves a zero syndrome
			exp_corr = (sel < 12);
			base  = ADDR_W'(32'h200 + 32 * i);
			load_packet(base, cnt, typ, flips, '0);
			run_parse(base);
			check_results(exp_corr, 1'b0, 1'b0, cnt, typ);
		end
		end_test("start while busy and random packets");
	endtask

	initial begin
		reset            = 1'b1;
		load_we_i        = 1'b0;
		load_addr_i      = '0;
		load_data_i      = '0;
		start_i          = 1'b0;
		addr_hdr_i       = '0;
		ignore_ecc_err_i = 1'b0;
		repeat (5) @(posedge clk);
		#10;
		reset = 1'b0;
		test_clean_packet();
		test_bad_crc();
		test_single_flip();
		test_double_flip();
		test_restart_and_random();
		$display("Tests passed: %0d, failed: %0d, check errors: %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- project.f
verilog/pkt_parse_pkg.sv
verilog/pkt_mem.sv
verilog/hdr_ecc_check.sv
verilog/payload_crc.sv
verilog/parse_status.sv
verilog/pkt_parse_top.sv
test/pkt_parse_checker.sv
test/tb_pkt_parse.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the parser testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
	--top-module tb_pkt_parse -Mdir obj_dir -o tb_pkt_parse \
	-f project.f

./obj_dir/tb_pkt_parse | tee sim.log

if grep -qx "All tests passed" sim.log; then
	echo "Simulation result: PASS"
	exit 0
else
	echo "Simulation result: FAIL"
	exit 1
fi
